// ==== rv32_exec.f ====
+incdir+common
common/rv32_pkg.sv
alu/alu.sv
hdl/imm_decode.sv
hdl/reg_file.sv
hdl/pc_unit.sv
hdl/exec_control.sv
hdl/rv32_exec_top.sv
tb/rv32_exec_properties.sv
tb/tb_rv32_exec.sv

// ==== Makefile ====
SRCS := $(filter-out +%,$(shell cat rv32_exec.f)) common/rv32_defines.svh

obj_dir/Vtb_rv32_exec: rv32_exec.f $(SRCS)
	verilator --binary --timing --assert --timescale 1ns/100ps \
	  --top-module tb_rv32_exec -f rv32_exec.f

run: obj_dir/Vtb_rv32_exec
	@out="$$(./obj_dir/Vtb_rv32_exec +verilator+error+limit+1000)"; \
	  echo "$$out"; \
	  echo "$$out" | grep -qx 'Result: PASSED'

clean:
	rm -rf obj_dir

.PHONY: run clean

// ==== tb/tb_rv32_exec.sv ====
`default_nettype none
`timescale 1ns/100ps

`include "rv32_defines.svh"

module tb_rv32_exec;

  logic              clk;
  logic              rst;
  logic              instr_valid;
  logic [31:0]       instr;
  logic              busy;
  logic              done;
  rv32_pkg::retire_t retire;

  integer            seed = 32'hb8bd7b06;
  logic [31:0]       mregs [32];
  logic [31:0]       mpc;
  rv32_pkg::retire_t last_ret;
  string             cur_test = "reset";
  int                test_cycles = 0;
  int                test_limit = 200;
  int                errors = 0;
  int                checks = 0;
  int                tests = 0;
  int                test_errors = 0;
  int                test_instrs = 0;
  int                issued = 0;
  int                done_seen = 0;

  rv32_exec_top u_rv32_exec_top (
    .clk        (clk),
    .rst        (rst),
    .instr_valid(instr_valid),
    .instr      (instr),
    .busy       (busy),
    .done       (done),
    .retire     (retire)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  always @(negedge clk) begin
    if (done) done_seen++;
  end

  // Watchdog with a per-test limit
  initial begin
    while (test_cycles <= test_limit) begin
      @(posedge clk);
      test_cycles++;
    end
    $display("Timeout: test %s ran past %0d cycles", cur_test, test_limit);
    $display("Result: FAILED");
    $finish;
  end

  //////////////////////////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] arith(input logic [2:0] f3, input logic alt,
                                        input logic [31:0] x, input logic [31:0] y);
    case (f3)
      3'b000:  return alt ? x - y : x + y;
      3'b001:  return x << y[4:0];
      3'b010:  return {31'd0, $signed(x) < $signed(y)};
      3'b011:  return {31'd0, x < y};
      3'b100:  return x ^ y;
      3'b101:  return alt ? 32'($signed(x) >>> y[4:0]) : x >> y[4:0];
      3'b110:  return x | y;
      default: return x & y;
    endcase
  endfunction

  task automatic predict(input logic [31:0] ins, output rv32_pkg::retire_t exp);
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] imm_i;
    logic [31:0] imm_s;
    logic [31:0] imm_b;
    logic [31:0] imm_j;
    logic [2:0]  f3;
    logic        take;
    f3    = ins[14:12];
    a     = mregs[ins[19:15]];
    b     = mregs[ins[24:20]];
    imm_i = {{20{ins[31]}}, ins[31:20]};
    imm_s = {{20{ins[31]}}, ins[31:25], ins[11:7]};
    imm_b = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
    imm_j = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
    exp         = '0;
    exp.pc      = mpc;
    exp.rd      = ins[11:7];
    exp.next_pc = mpc + 32'd4;
    case (ins[6:0])
      7'b0010011: begin
        exp.wr_en  = 1'b1;
        exp.result = arith(f3, f3 == 3'b101 && ins[30], a, imm_i);
      end
      7'b0110011: begin
        exp.wr_en  = 1'b1;
        exp.result = arith(f3, ins[30], a, b);
      end
      7'b0110111: begin
        exp.wr_en  = 1'b1;
        exp.result = {ins[31:12], 12'h000};
      end
      7'b0010111: begin
        exp.wr_en  = 1'b1;
        exp.result = mpc + {ins[31:12], 12'h000};
      end
      7'b0000011: begin
        exp.mem_access = 1'b1;
        exp.result     = a + imm_i;
      end
      7'b0100011: begin
        exp.mem_access = 1'b1;
        exp.result     = a + imm_s;
      end
      7'b1100011: begin
        case (f3)
          3'b000:  take = (a == b);
          3'b001:  take = (a != b);
          3'b100:  take = ($signed(a) < $signed(b));
          3'b101:  take = ($signed(a) >= $signed(b));
          3'b110:  take = (a < b);
          3'b111:  take = (a >= b);
          default: take = 1'b0;
        endcase
        // Result carries the branch target
        exp.result = mpc + imm_b;
        if (take) exp.next_pc = mpc + imm_b;
      end
      7'b1101111: begin
        exp.wr_en   = 1'b1;
        exp.result  = mpc + 32'd4;
        exp.next_pc = mpc + imm_j;
      end
      7'b1100111: begin
        exp.wr_en   = 1'b1;
        exp.result  = mpc + 32'd4;
        exp.next_pc = (a + imm_i) & ~32'd1;
      end
      default: exp.illegal = 1'b1;
    endcase
    if (exp.rd == 5'd0) exp.wr_en = 1'b0;
    if (exp.wr_en) mregs[exp.rd] = exp.result;
    mpc = exp.next_pc;
  endtask

  //////////////////////////////////////////////////////////////////////
  // Stimulus and checking
  //////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] next_rand();
    return $random(seed);
  endfunction

  function automatic logic [31:0] arith_instr();
    logic [31:0] ins;
    logic [31:0] sel;
    ins = next_rand();
    sel = next_rand();
    if (sel[0]) begin
      ins[6:0]   = 7'b0110011;
      ins[31:25] = (sel[1] && ins[14:12] inside {3'b000, 3'b101}) ? 7'h20 : 7'h00;
    end else begin
      ins[6:0] = 7'b0010011;
      if (ins[14:12] == 3'b001) ins[31:25] = 7'h00;
      if (ins[14:12] == 3'b101) ins[31:25] = sel[1] ? 7'h20 : 7'h00;
    end
    if (sel[5:2] == 4'd0) ins[11:7] = 5'd0;
    return ins;
  endfunction

  function automatic logic [31:0] upper_mem_instr();
    logic [31:0] ins;
    logic [31:0] sel;
    ins = next_rand();
    sel = next_rand();
    case (sel[1:0])
      2'd0:    ins[6:0] = 7'b0110111;
      2'd1:    ins[6:0] = 7'b0010111;
      2'd2:    ins[6:0] = 7'b0000011;
      default: ins[6:0] = 7'b0100011;
    endcase
    if (sel[1]) ins[14:12] = 3'b010;
    return ins;
  endfunction

  function automatic logic [31:0] flow_instr();
    logic [31:0] ins;
    logic [31:0] sel;
    ins = next_rand();
    sel = next_rand();
    case (sel[1:0])
      2'd0: ins[6:0] = 7'b1101111;
      2'd1: begin
        ins[6:0]   = 7'b1100111;
        ins[14:12] = 3'b000;
      end
      default: begin
        ins[6:0] = 7'b1100011;
        // funct3 010 and 011 are not branches
        if (ins[14:13] == 2'b01) ins[13] = 1'b0;
        if (sel[3:2] == 2'd0) ins[24:20] = ins[19:15];
      end
    endcase
    return ins;
  endfunction

  function automatic logic [31:0] illegal_instr();
    logic [31:0] ins;
    do begin
      ins = next_rand();
    end while (ins[6:0] inside {7'b0000011, 7'b0010011, 7'b0010111, 7'b0100011,
                                7'b0110011, 7'b0110111, 7'b1100011, 7'b1100111,
                                7'b1101111});
    return ins;
  endfunction

  task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      test_errors++;
      $display("Error at %0t: %s = %h, expected %h", $time, name, got, exp);
    end
  endtask

  // Strobe one instruction and optionally keep strobing while busy
  task automatic issue(input logic [31:0] ins, input bit flood);
    rv32_pkg::retire_t exp;
    int                wait_cycles;
    predict(ins, exp);
    instr       = ins;
    instr_valid = 1'b1;
    wait_cycles = 0;
    do begin
      @(negedge clk);
      wait_cycles++;
      instr_valid = flood;
      instr       = next_rand();
      compare("busy", 32'(busy), 32'd1);
    end while (!done && wait_cycles < 6);
    issued++;
    test_instrs++;
    if (!done) begin
      errors++;
      test_errors++;
      $display("No done within %0d cycles for instruction %h", wait_cycles, ins);
    end else begin
      compare("done latency", wait_cycles, 32'd2);
      compare("retire.pc", retire.pc, exp.pc);
      compare("retire.result", retire.result, exp.result);
      compare("retire.next_pc", retire.next_pc, exp.next_pc);
      compare("retire.rd", 32'(retire.rd), 32'(exp.rd));
      compare("retire.wr_en", 32'(retire.wr_en), 32'(exp.wr_en));
      compare("retire.mem_access", 32'(retire.mem_access), 32'(exp.mem_access));
      compare("retire.illegal", 32'(retire.illegal), 32'(exp.illegal));
      last_ret = retire;
    end
    @(negedge clk);
    instr_valid = 1'b0;
    compare("done", 32'(done), 32'd0);
    compare("busy", 32'(busy), 32'd0);
  endtask

  task automatic begin_test(input string name, input int n);
    cur_test    = name;
    test_limit  = 4 * n + 100;
    test_cycles = 0;
    test_errors = 0;
    test_instrs = 0;
    tests++;
  endtask

  task automatic end_test();
    compare("done count", done_seen, issued);
    $display("Test %-8s %0d instructions, %0d errors", cur_test, test_instrs, test_errors);
  endtask

  initial begin
    rst         = 1'b1;
    instr_valid = 1'b0;
    instr       = 32'd0;
    mpc         = `RV32_RESET_PC;
    for (int i = 0; i < 32; i++) begin
      mregs[i] = 32'd0;
    end
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    begin_test("reset", 2);
    compare("busy", 32'(busy), 32'd0);
    compare("done", 32'(done), 32'd0);
    // add x5, x3, x4
    issue({7'h00, 5'd4, 5'd3, 3'b000, 5'd5, 7'b0110011}, 1'b0);
    compare("first retire.pc", last_ret.pc, `RV32_RESET_PC);
    compare("unwritten register sum", last_ret.result, 32'd0);
    // addi x6, x9, 0
    issue({12'd0, 5'd9, 3'b000, 5'd6, 7'b0010011}, 1'b0);
    compare("unwritten register", last_ret.result, 32'd0);
    end_test();

    begin_test("arith", 400);
    repeat (400) issue(arith_instr(), 1'b0);
    end_test();

    begin_test("upper", 80);
    repeat (80) issue(upper_mem_instr(), 1'b0);
    end_test();

    begin_test("flow", 160);
    repeat (160) issue(flow_instr(), 1'b0);
    end_test();

    begin_test("illegal", 40);
    repeat (40) issue(illegal_instr(), 1'b0);
    end_test();

    begin_test("busy", 30);
    repeat (15) begin
      issue(arith_instr(), 1'b1);
      issue(flow_instr(), 1'b1);
    end
    end_test();

    if (u_rv32_exec_top.u_control.u_props.fail_count != 0) begin
      $display("Assertion failures: %0d", u_rv32_exec_top.u_control.u_props.fail_count);
      errors += u_rv32_exec_top.u_control.u_props.fail_count;
    end
    $display("Tests %0d, instructions %0d, checks %0d, errors %0d",
             tests, issued, checks, errors);
    if (errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== tb/rv32_exec_properties.sv ====
`default_nettype none
`timescale 1ns/100ps

module rv32_exec_properties (
  input logic                  clk,
  input logic                  rst,
  input logic                  instr_valid,
  input logic                  busy,
  input logic                  done,
  input logic                  wr_en,
  input logic [4:0]            wr_addr,
  input rv32_pkg::exec_state_e state
);

  int   fail_count = 0;
  logic accept;

  // Strobe taken only in IDLE
  assign accept = instr_valid && !busy;

  //////////////////////////////////////////////////////////////////////
  // Control output properties
  //////////////////////////////////////////////////////////////////////

  a_done_one_cycle: assert property (@(posedge clk) disable iff (rst) done |=> !done)
    else begin
      fail_count++;
      $error("done high for more than one cycle");
    end

  a_done_after_strobe: assert property (@(posedge clk) disable iff (rst)
    done |-> $past(accept, 2))
    else begin
      fail_count++;
      $error("done without an accepted strobe two cycles before");
    end

  a_strobe_to_done: assert property (@(posedge clk) disable iff (rst)
    $past(accept, 2) |-> done)
    else begin
      fail_count++;
      $error("accepted strobe not followed by done two cycles later");
    end

  a_no_x0_write: assert property (@(posedge clk) disable iff (rst)
    wr_en |-> wr_addr != 5'd0)
    else begin
      fail_count++;
      $error("register write enabled for x0");
    end

  a_idle_not_busy: assert property (@(posedge clk) disable iff (rst)
    state == rv32_pkg::ST_IDLE |-> !busy)
    else begin
      fail_count++;
      $error("busy high in IDLE");
    end

endmodule

bind exec_control rv32_exec_properties u_props (
  .clk        (clk),
  .rst        (rst),
  .instr_valid(instr_valid),
  .busy       (busy),
  .done       (done),
  .wr_en      (wr_en),
  .wr_addr    (wr_addr),
  .state      (state)
);

`default_nettype wire

// ==== hdl/rv32_exec_top.sv ====
`default_nettype none
`timescale 1ns/100ps

module rv32_exec_top (
  input  logic              clk,
  input  logic              rst,
  input  logic              instr_valid,
  input  logic [31:0]       instr,
  output logic              busy,
  output logic              done,
  output rv32_pkg::retire_t retire
);

  logic [31:0]          cur_instr;
  logic [4:0]           rs1;
  logic [4:0]           rs2;
  logic [31:0]          rs1_data;
  logic [31:0]          rs2_data;
  logic                 wr_en;
  logic [4:0]           wr_addr;
  logic [31:0]          wr_data;
  logic [31:0]          alu_result;
  rv32_pkg::cmp_flags_t flags;
  logic [31:0]          pc;
  logic [31:0]          next_pc;
  rv32_pkg::pc_sel_e    pc_sel;
  logic                 pc_step;
  logic [31:0]          b_imm;

  exec_control u_control (
    .clk        (clk),
    .rst        (rst),
    .instr_valid(instr_valid),
    .instr      (instr),
    .alu_result (alu_result),
    .pc         (pc),
    .next_pc    (next_pc),
    .busy       (busy),
    .done       (done),
    .retire     (retire),
    .cur_instr  (cur_instr),
    .rs1        (rs1),
    .rs2        (rs2),
    .wr_en      (wr_en),
    .wr_addr    (wr_addr),
    .wr_data    (wr_data),
    .pc_sel     (pc_sel),
    .pc_step    (pc_step)
  );

  reg_file u_regs (
    .clk     (clk),
    .rst     (rst),
    .rs1     (rs1),
    .rs2     (rs2),
    .wr_en   (wr_en),
    .wr_addr (wr_addr),
    .wr_data (wr_data),
    .rs1_data(rs1_data),
    .rs2_data(rs2_data)
  );

  alu u_alu (
    .instruction(cur_instr),
    .op_a       (rs1_data),
    .op_b       (rs2_data),
    .pc         (pc),
    .out        (alu_result),
    .flags      (flags)
  );

  // Branch offset for the pc unit
  imm_decode u_imm (
    .instr(cur_instr),
    .i_imm(),
    .s_imm(),
    .b_imm(b_imm),
    .u_imm(),
    .j_imm()
  );

  pc_unit u_pc (
    .clk        (clk),
    .rst        (rst),
    .pc_step    (pc_step),
    .pc_sel     (pc_sel),
    .funct3     (cur_instr[14:12]),
    .flags      (flags),
    .b_imm      (b_imm),
    .jump_target(alu_result),
    .pc         (pc),
    .next_pc    (next_pc)
  );

endmodule

`default_nettype wire

// ==== hdl/exec_control.sv ====
`default_nettype none
`timescale 1ns/100ps

module exec_control (
  input  logic              clk,
  input  logic              rst,
  input  logic              instr_valid,
  input  logic [31:0]       instr,
  input  logic [31:0]       alu_result,
  input  logic [31:0]       pc,
  input  logic [31:0]       next_pc,
  output logic              busy,
  output logic              done,
  output rv32_pkg::retire_t retire,
  output logic [31:0]       cur_instr,
  output logic [4:0]        rs1,
  output logic [4:0]        rs2,
  output logic              wr_en,
  output logic [4:0]        wr_addr,
  output logic [31:0]       wr_data,
  output rv32_pkg::pc_sel_e pc_sel,
  output logic              pc_step
);

  rv32_pkg::exec_state_e state;
  rv32_pkg::opcode_e     opcode;
  rv32_pkg::decode_t     dec;
  logic [31:0]           instr_q;
  logic [31:0]           link_addr;
  logic [4:0]            rd;
  logic                  in_exec;

  //////////////////////////////////////////////////////////////////////
  // State machine and instruction latch
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= rv32_pkg::ST_IDLE;
    end else begin
      case (state)
        rv32_pkg::ST_IDLE:    if (instr_valid) state <= rv32_pkg::ST_DECODE;
        rv32_pkg::ST_DECODE:  state <= rv32_pkg::ST_EXECUTE;
        default:              state <= rv32_pkg::ST_IDLE;
      endcase
    end
  end

  // Strobes while busy are dropped here
  always_ff @(posedge clk) begin
    if (state == rv32_pkg::ST_IDLE && instr_valid) begin
      instr_q <= instr;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Opcode decode
  //////////////////////////////////////////////////////////////////////

  assign opcode    = rv32_pkg::opcode_e'(instr_q[6:0]);
  assign rd        = instr_q[11:7];
  assign link_addr = pc + 32'd4;

  always_comb begin
    dec        = '0;
    dec.pc_sel = rv32_pkg::PC_SEQ;
    case (opcode)
      rv32_pkg::OPC_OP_IMM,
      rv32_pkg::OPC_OP,
      rv32_pkg::OPC_LUI,
      rv32_pkg::OPC_AUIPC: dec.wr_en = 1'b1;
      rv32_pkg::OPC_LOAD,
      rv32_pkg::OPC_STORE: dec.mem_access = 1'b1;
      rv32_pkg::OPC_JAL,
      rv32_pkg::OPC_JALR: begin
        dec.wr_en  = 1'b1;
        dec.link   = 1'b1;
        dec.pc_sel = rv32_pkg::PC_JUMP;
      end
      rv32_pkg::OPC_BRANCH: dec.pc_sel = rv32_pkg::PC_BRANCH;
      default: dec.illegal = 1'b1;
    endcase
    // x0 is never a destination
    if (rd == 5'd0) dec.wr_en = 1'b0;
  end

  //////////////////////////////////////////////////////////////////////
  // Outputs and retire
  //////////////////////////////////////////////////////////////////////

  assign in_exec   = (state == rv32_pkg::ST_EXECUTE);
  assign busy      = (state != rv32_pkg::ST_IDLE);
  assign done      = in_exec;
  assign pc_step   = in_exec;
  assign pc_sel    = dec.pc_sel;
  assign cur_instr = instr_q;
  assign rs1       = instr_q[19:15];
  assign rs2       = instr_q[24:20];
  assign wr_en     = in_exec & dec.wr_en;
  assign wr_addr   = rd;
  assign wr_data   = dec.link ? link_addr : alu_result;

  always_comb begin
    retire.pc         = pc;
    retire.result     = wr_data;
    retire.next_pc    = next_pc;
    retire.rd         = rd;
    retire.wr_en      = dec.wr_en;
    retire.mem_access = dec.mem_access;
    retire.illegal    = dec.illegal;
  end

endmodule

`default_nettype wire

// ==== hdl/pc_unit.sv ====
`default_nettype none
`timescale 1ns/100ps

`include "rv32_defines.svh"

module pc_unit (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 pc_step,
  input  rv32_pkg::pc_sel_e    pc_sel,
  input  logic [2:0]           funct3,
  input  rv32_pkg::cmp_flags_t flags,
  input  logic [31:0]          b_imm,
  input  logic [31:0]          jump_target,
  output logic [31:0]          pc,
  output logic [31:0]          next_pc
);

  logic        taken;
  logic [31:0] seq_pc;

  assign seq_pc = pc + 32'd4;

  // Branch condition from funct3
  always_comb begin
    case (funct3)
      rv32_pkg::FUNCT3_BEQ:  taken = flags.eq;
      rv32_pkg::FUNCT3_BNE:  taken = flags.neq;
      rv32_pkg::FUNCT3_BLT:  taken = flags.lt;
      rv32_pkg::FUNCT3_BGE:  taken = flags.ge;
      rv32_pkg::FUNCT3_BLTU: taken = flags.ltu;
      rv32_pkg::FUNCT3_BGEU: taken = flags.geu;
      default:               taken = 1'b0;
    endcase
  end

  always_comb begin
    case (pc_sel)
      rv32_pkg::PC_BRANCH: next_pc = taken ? pc + b_imm : seq_pc;
      rv32_pkg::PC_JUMP:   next_pc = jump_target;
      default:             next_pc = seq_pc;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      pc <= `RV32_RESET_PC;
    end else if (pc_step) begin
      pc <= next_pc;
    end
  end

endmodule

`default_nettype wire

// ==== hdl/reg_file.sv ====
`default_nettype none
`timescale 1ns/100ps

`include "rv32_defines.svh"

module reg_file (
  input  logic        clk,
  input  logic        rst,
  input  logic [4:0]  rs1,
  input  logic [4:0]  rs2,
  input  logic        wr_en,
  input  logic [4:0]  wr_addr,
  input  logic [31:0] wr_data,
  output logic [31:0] rs1_data,
  output logic [31:0] rs2_data
);

  logic [31:0] regs [`RV32_NUM_REGS];

  //////////////////////////////////////////////////////////////////////
  // Write port
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < `RV32_NUM_REGS; i++) begin
        regs[i] <= 32'd0;
      end
    end else if (wr_en && wr_addr != 5'd0) begin
      regs[wr_addr] <= wr_data;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Read ports
  //////////////////////////////////////////////////////////////////////

  // x0 reads as zero
  assign rs1_data = (rs1 == 5'd0) ? 32'd0 : regs[rs1];
  assign rs2_data = (rs2 == 5'd0) ? 32'd0 : regs[rs2];

endmodule

`default_nettype wire

// ==== hdl/imm_decode.sv ====
`default_nettype none
`timescale 1ns/100ps

module imm_decode (
  input  logic [31:0] instr,
  output logic [31:0] i_imm,
  output logic [31:0] s_imm,
  output logic [31:0] b_imm,
  output logic [31:0] u_imm,
  output logic [31:0] j_imm
);

  logic sign;

  assign sign = instr[31];

  // Loads, OP_IMM and JALR
  assign i_imm = {{20{sign}}, instr[31:20]};

  assign s_imm = {{20{sign}}, instr[31:25], instr[11:7]};

  // Branch offsets are in units of two bytes
  assign b_imm = {
    {19{sign}},
    instr[31],
    instr[7],
    instr[30:25],
    instr[11:8],
    1'b0
  };

  assign u_imm = {instr[31:12], 12'b0};

  assign j_imm = {
    {11{sign}},
    instr[31],
    instr[19:12],
    instr[20],
    instr[30:21],
    1'b0
  };

endmodule

`default_nettype wire

// ==== alu/alu.sv ====
`default_nettype none
`timescale 1ns/100ps

module alu (
  input  logic [31:0]          instruction,
  input  logic [31:0]          op_a,
  input  logic [31:0]          op_b,
  input  logic [31:0]          pc,
  output logic [31:0]          out,
  output rv32_pkg::cmp_flags_t flags
);

  logic [31:0]       i_imm;
  logic [31:0]       s_imm;
  logic [31:0]       b_imm;
  logic [31:0]       u_imm;
  logic [31:0]       j_imm;
  rv32_pkg::opcode_e opcode;
  logic [2:0]        funct3;
  logic [4:0]        shamt;
  logic              alt;

  imm_decode u_imm_decode (
    .instr(instruction),
    .i_imm(i_imm),
    .s_imm(s_imm),
    .b_imm(b_imm),
    .u_imm(u_imm),
    .j_imm(j_imm)
  );

  assign opcode = rv32_pkg::opcode_e'(instruction[6:0]);
  assign funct3 = instruction[14:12];
  assign shamt  = instruction[24:20];
  // SUB and SRA select
  assign alt    = instruction[30];

  assign flags.eq  = (op_a == op_b);
  assign flags.neq = (op_a != op_b);
  assign flags.lt  = ($signed(op_a) < $signed(op_b));
  assign flags.ltu = (op_a < op_b);
  assign flags.ge  = ($signed(op_a) >= $signed(op_b));
  assign flags.geu = (op_a >= op_b);

  always_comb begin
    out = 32'd0;
    case (opcode)
      rv32_pkg::OPC_OP_IMM: begin
        case (funct3)
          rv32_pkg::FUNCT3_ADDI:  out = op_a + i_imm;
          rv32_pkg::FUNCT3_SLTI:  out = {31'd0, $signed(op_a) < $signed(i_imm)};
          rv32_pkg::FUNCT3_SLTIU: out = {31'd0, op_a < i_imm};
          rv32_pkg::FUNCT3_ANDI:  out = op_a & i_imm;
          rv32_pkg::FUNCT3_ORI:   out = op_a | i_imm;
          rv32_pkg::FUNCT3_XORI:  out = op_a ^ i_imm;
          rv32_pkg::FUNCT3_SLLI:  out = op_a << shamt;
          rv32_pkg::FUNCT3_SRLI_SRAI:
            out = alt ? 32'($signed(op_a) >>> shamt) : op_a >> shamt;
          default: out = 32'd0;
        endcase
      end
      rv32_pkg::OPC_OP: begin
        case (funct3)
          rv32_pkg::FUNCT3_ADD_SUB: out = alt ? op_a - op_b : op_a + op_b;
          rv32_pkg::FUNCT3_SLT:     out = {31'd0, flags.lt};
          rv32_pkg::FUNCT3_SLTU:    out = {31'd0, flags.ltu};
          rv32_pkg::FUNCT3_AND:     out = op_a & op_b;
          rv32_pkg::FUNCT3_OR:      out = op_a | op_b;
          rv32_pkg::FUNCT3_XOR:     out = op_a ^ op_b;
          rv32_pkg::FUNCT3_SLL:     out = op_a << op_b[4:0];
          rv32_pkg::FUNCT3_SRL_SRA:
            out = alt ? 32'($signed(op_a) >>> op_b[4:0]) : op_a >> op_b[4:0];
          default: out = 32'd0;
        endcase
      end
      rv32_pkg::OPC_BRANCH: out = pc + b_imm;
      rv32_pkg::OPC_LUI:    out = u_imm;
      rv32_pkg::OPC_AUIPC:  out = pc + u_imm;
      rv32_pkg::OPC_LOAD:   out = op_a + i_imm;
      rv32_pkg::OPC_STORE:  out = op_a + s_imm;
      rv32_pkg::OPC_JAL:    out = pc + j_imm;
      rv32_pkg::OPC_JALR:   out = (op_a + i_imm) & ~32'd1;
      default:              out = 32'd0;
    endcase
  end

endmodule

`default_nettype wire

// ==== common/rv32_pkg.sv ====
`default_nettype none

package rv32_pkg;

  //////////////////////////////////////////////////////////////////////
  // Opcodes and states
  //////////////////////////////////////////////////////////////////////

  typedef enum logic [6:0] {
    OPC_LOAD   = 7'b0000011,
    OPC_OP_IMM = 7'b0010011,
    OPC_AUIPC  = 7'b0010111,
    OPC_STORE  = 7'b0100011,
    OPC_OP     = 7'b0110011,
    OPC_LUI    = 7'b0110111,
    OPC_BRANCH = 7'b1100011,
    OPC_JALR   = 7'b1100111,
    OPC_JAL    = 7'b1101111
  } opcode_e;

  typedef enum logic [1:0] {
    ST_IDLE    = 2'd0,
    ST_DECODE  = 2'd1,
    ST_EXECUTE = 2'd2
  } exec_state_e;

  typedef enum logic [1:0] {
    PC_SEQ    = 2'd0,
    PC_BRANCH = 2'd1,
    PC_JUMP   = 2'd2
  } pc_sel_e;

  //////////////////////////////////////////////////////////////////////
  // funct3 encodings
  //////////////////////////////////////////////////////////////////////

  localparam logic [2:0] FUNCT3_ADDI      = 3'b000;
  localparam logic [2:0] FUNCT3_SLLI      = 3'b001;
  localparam logic [2:0] FUNCT3_SLTI      = 3'b010;
  localparam logic [2:0] FUNCT3_SLTIU     = 3'b011;
  localparam logic [2:0] FUNCT3_XORI      = 3'b100;
  localparam logic [2:0] FUNCT3_SRLI_SRAI = 3'b101;
  localparam logic [2:0] FUNCT3_ORI       = 3'b110;
  localparam logic [2:0] FUNCT3_ANDI      = 3'b111;

  localparam logic [2:0] FUNCT3_ADD_SUB = 3'b000;
  localparam logic [2:0] FUNCT3_SLL     = 3'b001;
  localparam logic [2:0] FUNCT3_SLT     = 3'b010;
  localparam logic [2:0] FUNCT3_SLTU    = 3'b011;
  localparam logic [2:0] FUNCT3_XOR     = 3'b100;
  localparam logic [2:0] FUNCT3_SRL_SRA = 3'b101;
  localparam logic [2:0] FUNCT3_OR      = 3'b110;
  localparam logic [2:0] FUNCT3_AND     = 3'b111;

  localparam logic [2:0] FUNCT3_BEQ  = 3'b000;
  localparam logic [2:0] FUNCT3_BNE  = 3'b001;
  localparam logic [2:0] FUNCT3_BLT  = 3'b100;
  localparam logic [2:0] FUNCT3_BGE  = 3'b101;
  localparam logic [2:0] FUNCT3_BLTU = 3'b110;
  localparam logic [2:0] FUNCT3_BGEU = 3'b111;

  //////////////////////////////////////////////////////////////////////
  // Structs
  //////////////////////////////////////////////////////////////////////

  typedef struct packed {
    logic eq;
    logic neq;
    logic lt;
    logic ltu;
    logic ge;
    logic geu;
  } cmp_flags_t;

  // Per-instruction control decisions
  typedef struct packed {
    logic    wr_en;
    logic    mem_access;
    logic    illegal;
    logic    link;
    pc_sel_e pc_sel;
  } decode_t;

  typedef struct packed {
    logic [31:0] pc;
    logic [31:0] result;
    logic [31:0] next_pc;
    logic [4:0]  rd;
    logic        wr_en;
    logic        mem_access;
    logic        illegal;
  } retire_t;

endpackage

`default_nettype wire

// ==== common/rv32_defines.svh ====
`ifndef RV32_DEFINES_SVH
`define RV32_DEFINES_SVH

// Fetch address after reset
`define RV32_RESET_PC 32'h0000_1000

// Architectural integer registers
`define RV32_NUM_REGS 32

`endif
